// ==== design/usb_phy_pkg.sv ====
`default_nettype none

package usb_phy_pkg;

  ////////////////////////////////////////////////////////////
  // Register bus
  ////////////////////////////////////////////////////////////

  // Data width of the strobe bus
  localparam int unsigned REG_DW = 16;

  // Register map
  typedef enum logic [1:0] {
    ADDR_DRIVE = 2'd0,
    ADDR_SENSE = 2'd1,
    ADDR_CTRL  = 2'd2
  } reg_addr_e;

  // Override register with en in the MSB
  typedef struct packed {
    logic en;
    logic dp;
    logic dn;
    logic d;
    logic se0;
    logic oe;
    logic dp_pullup_en;
    logic dn_pullup_en;
    logic rx_enable;
  } phy_drive_t;

  // Synchronized receive pins plus engine transmit values
  typedef struct packed {
    logic rx_dp;
    logic rx_dn;
    logic rx_d;
    logic pwr_sense;
    logic tx_dp;
    logic tx_dn;
    logic tx_d;
    logic tx_se0;
    logic tx_oe;
  } phy_sense_t;

  ////////////////////////////////////////////////////////////
  // Line coding
  ////////////////////////////////////////////////////////////

  // Encoded as {dp, dn} so the pins fall straight out
  typedef enum logic [1:0] {
    LS_SE0 = 2'b00,
    LS_J   = 2'b10,
    LS_K   = 2'b01,
    LS_SE1 = 2'b11
  } line_state_e;

  // Serializer FSM
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_DATA,
    TX_EOP_SE0,
    TX_EOP_J
  } tx_state_e;

endpackage

`default_nettype wire

// ==== design/usb_pin_if.sv ====
`default_nettype none

// Engine side of the pins, before the override mux
interface usb_pin_if;

  // Transmit line values from the serializer
  logic tx_d;
  logic tx_se0;
  logic tx_dp;
  logic tx_dn;
  logic tx_oe;

  // Static enables from the control register
  logic dp_pullup_en;
  logic dn_pullup_en;
  logic rx_enable;

  // Serializer owns the transmit bits
  modport serializer (
    output tx_d, tx_se0, tx_dp, tx_dn, tx_oe
  );

  // Register block owns pull-ups and receiver enable
  modport ctrl (
    output dp_pullup_en, dn_pullup_en, rx_enable
  );

  // Mux only observes
  modport iomux (
    input tx_d, tx_se0, tx_dp, tx_dn, tx_oe,
    input dp_pullup_en, dn_pullup_en, rx_enable
  );

endinterface

`default_nettype wire

// ==== design/usb_phy_csr.sv ====
`default_nettype none

module usb_phy_csr (
  input  logic                           clk_i,
  input  logic                           rst_n_i,

  // Strobe bus
  input  logic                           reg_we_i,
  input  logic                           reg_re_i,
  input  usb_phy_pkg::reg_addr_e         reg_addr_i,
  input  logic [usb_phy_pkg::REG_DW-1:0] reg_wdata_i,
  output logic [usb_phy_pkg::REG_DW-1:0] reg_rdata_o,

  // To and from the pin mux
  output usb_phy_pkg::phy_drive_t        drive_o,
  input  usb_phy_pkg::phy_sense_t        sense_i,

  // Engine-side enables
  usb_pin_if.ctrl                        pins
);
  import usb_phy_pkg::*;

  localparam int unsigned DriveW = $bits(phy_drive_t);
  localparam int unsigned SenseW = $bits(phy_sense_t);
  localparam int unsigned CtrlW  = 3;

  phy_drive_t        drive_q;
  logic [CtrlW-1:0]  ctrl_q;
  logic [REG_DW-1:0] rdata_d;

  ////////////////////////////////////////////////////////////
  // Writable registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      drive_q <= '0;
      ctrl_q  <= '0;
    end else if (reg_we_i) begin
      case (reg_addr_i)
        ADDR_DRIVE: drive_q <= phy_drive_t'(reg_wdata_i[DriveW-1:0]);
        ADDR_CTRL:  ctrl_q  <= reg_wdata_i[CtrlW-1:0];
        // Sense is read-only, unmapped addresses drop the write
        default: ;
      endcase
    end
  end

  assign drive_o = drive_q;

  // Control bits feed the engine side of the mux
  assign pins.dp_pullup_en = ctrl_q[0];
  assign pins.dn_pullup_en = ctrl_q[1];
  assign pins.rx_enable    = ctrl_q[2];

  ////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////

  // Zero-extend whichever source is addressed
  always_comb begin
    rdata_d = '0;
    case (reg_addr_i)
      ADDR_DRIVE: rdata_d[DriveW-1:0] = drive_q;
      ADDR_SENSE: rdata_d[SenseW-1:0] = sense_i;
      ADDR_CTRL:  rdata_d[CtrlW-1:0]  = ctrl_q;
      default:    rdata_d = '0;
    endcase
  end

  // Data valid the cycle after the strobe, held until the next read
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      reg_rdata_o <= '0;
    end else if (reg_re_i) begin
      reg_rdata_o <= rdata_d;
    end
  end

  // Master never strobes read and write together
  a_no_rw_collision : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(reg_we_i && reg_re_i)
  );

endmodule

`default_nettype wire

// ==== design/usb_tx_serializer.sv ====
`default_nettype none

module usb_tx_serializer #(
  parameter int unsigned ClksPerBit = 4
) (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic [7:0]    tx_byte_i,
  input  logic          tx_valid_i,
  output logic          tx_busy_o,
  usb_pin_if.serializer pins
);
  import usb_phy_pkg::*;

  localparam int unsigned     CntW       = (ClksPerBit > 1) ? $clog2(ClksPerBit) : 1;
  localparam logic [CntW-1:0] CntMax     = CntW'(ClksPerBit - 1);
  localparam logic [2:0]      StuffLimit = 3'd6;

  tx_state_e       state_q;
  logic [CntW-1:0] cnt_q;
  logic [3:0]      bit_idx_q;  // data bits already on the line
  logic [2:0]      ones_q;     // run of 1s for stuffing
  logic            level_q;    // NRZI level, 1 is J
  logic            eop_bit_q;  // second SE0 bit time
  logic [7:0]      byte_q;
  logic            bit_end;
  logic            next_bit;
  line_state_e     line_state;

  assign bit_end  = (cnt_q == CntMax);
  assign next_bit = byte_q[bit_idx_q[2:0]];

  // Byte capture on accepted strobe
  always_ff @(posedge clk_i) begin
    if (state_q == TX_IDLE && tx_valid_i) begin
      byte_q <= tx_byte_i;
    end
  end

  // Bit period counter, restarts at every bit boundary
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (state_q == TX_IDLE || bit_end) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // FSM and NRZI
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= TX_IDLE;
      bit_idx_q <= '0;
      ones_q    <= '0;
      level_q   <= 1'b1;
      eop_bit_q <= 1'b0;
    end else begin
      case (state_q)
        TX_IDLE: begin
          // First data bit goes out straight from the input byte
          if (tx_valid_i) begin
            state_q   <= TX_DATA;
            bit_idx_q <= 4'd1;
            ones_q    <= tx_byte_i[0] ? 3'd1 : 3'd0;
            level_q   <= tx_byte_i[0] ? level_q : ~level_q;
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            if (ones_q == StuffLimit) begin
              // Stuffed 0 toggles, index holds
              ones_q  <= '0;
              level_q <= ~level_q;
            end else if (bit_idx_q == 4'd8) begin
              state_q   <= TX_EOP_SE0;
              eop_bit_q <= 1'b0;
            end else begin
              bit_idx_q <= bit_idx_q + 4'd1;
              ones_q    <= next_bit ? ones_q + 3'd1 : 3'd0;
              level_q   <= next_bit ? level_q : ~level_q;
            end
          end
        end
        TX_EOP_SE0: begin
          // Two bit times of SE0
          if (bit_end) begin
            if (eop_bit_q) begin
              state_q <= TX_EOP_J;
              level_q <= 1'b1;
            end else begin
              eop_bit_q <= 1'b1;
            end
          end
        end
        TX_EOP_J: begin
          if (bit_end) begin
            state_q <= TX_IDLE;
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  // Line state from FSM and level
  always_comb begin
    case (state_q)
      TX_DATA:    line_state = level_q ? LS_J : LS_K;
      TX_EOP_SE0: line_state = LS_SE0;
      default:    line_state = LS_J;
    endcase
  end

  assign {pins.tx_dp, pins.tx_dn} = line_state;
  assign pins.tx_se0 = (line_state == LS_SE0);
  assign pins.tx_d   = level_q;
  assign pins.tx_oe  = (state_q != TX_IDLE);
  assign tx_busy_o   = (state_q != TX_IDLE);

  // Driven line never shows SE1
  a_no_se1_driven : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    pins.tx_oe |-> !(pins.tx_dp && pins.tx_dn)
  );

endmodule

`default_nettype wire

// ==== design/usb_iomux.sv ====
`default_nettype none

module usb_iomux (
  input  logic                    clk_i,
  input  logic                    rst_n_i,

  // Asynchronous pin inputs
  input  logic                    usb_rx_d_i,
  input  logic                    usb_rx_dp_i,
  input  logic                    usb_rx_dn_i,
  input  logic                    usb_sense_i,

  // Register side
  input  usb_phy_pkg::phy_drive_t drive_i,
  output usb_phy_pkg::phy_sense_t sense_o,

  // Engine side
  usb_pin_if.iomux                pins,

  // Pin outputs
  output logic                    usb_tx_d_o,
  output logic                    usb_tx_se0_o,
  output logic                    usb_tx_dp_o,
  output logic                    usb_tx_dn_o,
  output logic                    usb_tx_oe_o,
  output logic                    usb_dp_pullup_en_o,
  output logic                    usb_dn_pullup_en_o,
  output logic                    usb_rx_enable_o
);
  import usb_phy_pkg::*;

  logic [3:0]  sync_meta_q;
  logic [3:0]  sync_q;
  logic        rx_dp;
  logic        rx_dn;
  logic        rx_d;
  logic        pwr_sense;
  line_state_e out_line;

  ////////////////////////////////////////////////////////////
  // Input synchronizer
  ////////////////////////////////////////////////////////////

  // Two flops, first one may go metastable
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_meta_q <= '0;
      sync_q      <= '0;
    end else begin
      sync_meta_q <= {usb_rx_dp_i, usb_rx_dn_i, usb_rx_d_i, usb_sense_i};
      sync_q      <= sync_meta_q;
    end
  end

  assign {rx_dp, rx_dn, rx_d, pwr_sense} = sync_q;

  // Sense shows engine values ahead of the override
  assign sense_o.rx_dp     = rx_dp;
  assign sense_o.rx_dn     = rx_dn;
  assign sense_o.rx_d      = rx_d;
  assign sense_o.pwr_sense = pwr_sense;
  assign sense_o.tx_dp     = pins.tx_dp;
  assign sense_o.tx_dn     = pins.tx_dn;
  assign sense_o.tx_d      = pins.tx_d;
  assign sense_o.tx_se0    = pins.tx_se0;
  assign sense_o.tx_oe     = pins.tx_oe;

  ////////////////////////////////////////////////////////////
  // Output override mux
  ////////////////////////////////////////////////////////////

  // Static enables
  always_comb begin
    if (drive_i.en) begin
      usb_dp_pullup_en_o = drive_i.dp_pullup_en;
      usb_dn_pullup_en_o = drive_i.dn_pullup_en;
      usb_rx_enable_o    = drive_i.rx_enable;
    end else begin
      usb_dp_pullup_en_o = pins.dp_pullup_en;
      usb_dn_pullup_en_o = pins.dn_pullup_en;
      usb_rx_enable_o    = pins.rx_enable;
    end
  end

  // Line signals as single selects each
  // Keeps dp/dn edges matched for jitter
  assign usb_tx_dp_o  = drive_i.en ? drive_i.dp  : pins.tx_dp;
  assign usb_tx_dn_o  = drive_i.en ? drive_i.dn  : pins.tx_dn;
  assign usb_tx_d_o   = drive_i.en ? drive_i.d   : pins.tx_d;
  assign usb_tx_se0_o = drive_i.en ? drive_i.se0 : pins.tx_se0;
  assign usb_tx_oe_o  = drive_i.en ? drive_i.oe  : pins.tx_oe;

  assign out_line = line_state_e'({usb_tx_dp_o, usb_tx_dn_o});

  // Engine path reaches the pins intact and never drives SE1
  a_engine_passthru : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !drive_i.en |-> (usb_tx_oe_o == pins.tx_oe) && !(usb_tx_oe_o && out_line == LS_SE1)
  );

endmodule

`default_nettype wire

// ==== design/usb_phy_top.sv ====
`default_nettype none

module usb_phy_top #(
  parameter int unsigned ClksPerBit = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,

  // Register bus
  input  logic                           reg_we_i,
  input  logic                           reg_re_i,
  input  usb_phy_pkg::reg_addr_e         reg_addr_i,
  input  logic [usb_phy_pkg::REG_DW-1:0] reg_wdata_i,
  output logic [usb_phy_pkg::REG_DW-1:0] reg_rdata_o,

  // Byte transmit
  input  logic [7:0]                     tx_byte_i,
  input  logic                           tx_valid_i,
  output logic                           tx_busy_o,

  // Async pin inputs
  input  logic                           usb_rx_d_i,
  input  logic                           usb_rx_dp_i,
  input  logic                           usb_rx_dn_i,
  input  logic                           usb_sense_i,

  // Pin outputs
  output logic                           usb_tx_d_o,
  output logic                           usb_tx_se0_o,
  output logic                           usb_tx_dp_o,
  output logic                           usb_tx_dn_o,
  output logic                           usb_tx_oe_o,
  output logic                           usb_dp_pullup_en_o,
  output logic                           usb_dn_pullup_en_o,
  output logic                           usb_rx_enable_o
);
  import usb_phy_pkg::*;

  phy_drive_t drive;
  phy_sense_t sense;

  // Engine-side pin bundle
  usb_pin_if pin_if ();

  ////////////////////////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////////////////////////

  usb_phy_csr u_csr (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_we_i    (reg_we_i),
    .reg_re_i    (reg_re_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .drive_o     (drive),
    .sense_i     (sense),
    .pins        (pin_if.ctrl)
  );

  usb_tx_serializer #(
    .ClksPerBit (ClksPerBit)
  ) u_tx (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .tx_byte_i  (tx_byte_i),
    .tx_valid_i (tx_valid_i),
    .tx_busy_o  (tx_busy_o),
    .pins       (pin_if.serializer)
  );

  usb_iomux u_iomux (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .usb_rx_d_i         (usb_rx_d_i),
    .usb_rx_dp_i        (usb_rx_dp_i),
    .usb_rx_dn_i        (usb_rx_dn_i),
    .usb_sense_i        (usb_sense_i),
    .drive_i            (drive),
    .sense_o            (sense),
    .pins               (pin_if.iomux),
    .usb_tx_d_o         (usb_tx_d_o),
    .usb_tx_se0_o       (usb_tx_se0_o),
    .usb_tx_dp_o        (usb_tx_dp_o),
    .usb_tx_dn_o        (usb_tx_dn_o),
    .usb_tx_oe_o        (usb_tx_oe_o),
    .usb_dp_pullup_en_o (usb_dp_pullup_en_o),
    .usb_dn_pullup_en_o (usb_dn_pullup_en_o),
    .usb_rx_enable_o    (usb_rx_enable_o)
  );

endmodule

`default_nettype wire

// ==== tests/usb_phy_tb.sv ====
`default_nettype none

module usb_phy_tb;
  import usb_phy_pkg::*;

  localparam int ClksPerBit = 4;
  localparam int RstCycles  = 8;
  localparam int BusyWait   = 8;

  // Idle engine bits in sense order {tx_dp, tx_dn, tx_d, tx_se0, tx_oe}
  localparam logic [4:0]  IdleTxSense = 5'b10100;
  // Idle J on the pins in order {d, se0, dp, dn, oe, dp_pu, dn_pu, rx_en}
  localparam logic [15:0] IdlePins    = {8'h00, 5'b10100, 3'b000};

  typedef enum logic [2:0] {K_WRITE, K_READ, K_PIN_SET, K_PIN_CHECK, K_SEND} kind_e;

  logic        clk;
  logic        rst_n;
  logic        reg_we;
  logic        reg_re;
  reg_addr_e   reg_addr;
  logic [15:0] reg_wdata;
  logic [15:0] reg_rdata;
  logic [7:0]  tx_byte;
  logic        tx_valid;
  logic        tx_busy;
  logic        usb_rx_d;
  logic        usb_rx_dp;
  logic        usb_rx_dn;
  logic        usb_sense;
  logic        usb_tx_d;
  logic        usb_tx_se0;
  logic        usb_tx_dp;
  logic        usb_tx_dn;
  logic        usb_tx_oe;
  logic        usb_dp_pullup_en;
  logic        usb_dn_pullup_en;
  logic        usb_rx_enable;
  logic [7:0]  pins_now;

  logic [31:0] lfsr_q = 32'hf3b176cd;
  int          errors = 0;
  int          cycles = 0;
  int          cycle_limit = 0;

  // Stimulus table as one queue per column
  string       t_name[$];
  kind_e       t_kind[$];
  reg_addr_e   t_addr[$];
  logic [15:0] t_data[$];
  logic [15:0] t_exp[$];

  usb_phy_top #(
    .ClksPerBit (ClksPerBit)
  ) dut (
    .clk_i              (clk),
    .rst_n_i            (rst_n),
    .reg_we_i           (reg_we),
    .reg_re_i           (reg_re),
    .reg_addr_i         (reg_addr),
    .reg_wdata_i        (reg_wdata),
    .reg_rdata_o        (reg_rdata),
    .tx_byte_i          (tx_byte),
    .tx_valid_i         (tx_valid),
    .tx_busy_o          (tx_busy),
    .usb_rx_d_i         (usb_rx_d),
    .usb_rx_dp_i        (usb_rx_dp),
    .usb_rx_dn_i        (usb_rx_dn),
    .usb_sense_i        (usb_sense),
    .usb_tx_d_o         (usb_tx_d),
    .usb_tx_se0_o       (usb_tx_se0),
    .usb_tx_dp_o        (usb_tx_dp),
    .usb_tx_dn_o        (usb_tx_dn),
    .usb_tx_oe_o        (usb_tx_oe),
    .usb_dp_pullup_en_o (usb_dp_pullup_en),
    .usb_dn_pullup_en_o (usb_dn_pullup_en),
    .usb_rx_enable_o    (usb_rx_enable)
  );

  assign pins_now = {usb_tx_d, usb_tx_se0, usb_tx_dp, usb_tx_dn, usb_tx_oe,
                     usb_dp_pullup_en, usb_dn_pullup_en, usb_rx_enable};

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Watchdog on total cycles
  initial begin
    wait (cycle_limit > 0);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Run timed out after %0d cycles", cycles);
    $display("errors: %0d", errors);
    $display("Finished with errors");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Galois form with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[14:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return r;
  endfunction

  // Drive fields en dp dn d se0 oe dp_pu dn_pu rx_en from the MSB
  function automatic logic [15:0] drive_pins(input logic [15:0] w);
    return {8'h00, w[5], w[4], w[7], w[6], w[3], w[2], w[1], w[0]};
  endfunction

  function automatic int entry_cycles(input kind_e k);
    case (k)
      K_WRITE:     return 2;
      K_READ:      return 3;
      K_PIN_SET:   return 4;
      K_PIN_CHECK: return 1;
      // Strobe, busy wait, up to 9 data bits plus EOP and a spare bit
      default:     return 4 + BusyWait + 16 * ClksPerBit;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [15:0] exp,
                             input logic [15:0] act);
    if (exp !== act) begin
      $display("error %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  function automatic void add_entry(input string name, input kind_e k, input reg_addr_e a,
                                    input logic [15:0] d, input logic [15:0] e);
    t_name.push_back(name);
    t_kind.push_back(k);
    t_addr.push_back(a);
    t_data.push_back(d);
    t_exp.push_back(e);
  endfunction

  task automatic bus_write(input reg_addr_e a, input logic [15:0] d);
    @(posedge clk);
    reg_we    <= 1'b1;
    reg_addr  <= a;
    reg_wdata <= d;
    @(posedge clk);
    reg_we    <= 1'b0;
  endtask

  // Data is registered on the strobe edge and sampled half a cycle later
  task automatic bus_read(input reg_addr_e a, output logic [15:0] d);
    @(posedge clk);
    reg_re   <= 1'b1;
    reg_addr <= a;
    @(posedge clk);
    reg_re   <= 1'b0;
    @(negedge clk);
    d = reg_rdata;
  endtask

  ////////////////////////////////////////////////////////////
  // Serializer checker
  ////////////////////////////////////////////////////////////

  // Checks {busy, oe, dp, dn, se0, d} mid-bit
  // With ovr set the drive value w is written as bit 2 starts
  task automatic send_byte(input string name, input logic [7:0] b, input logic ovr,
                           input logic [15:0] w);
    logic [3:0] line_q[$];
    logic       lvl;
    int         ones;
    int         waited;
    logic [5:0] exp;
    logic       ovr_on;
    lvl    = 1'b1;
    ones   = 0;
    ovr_on = 1'b0;
    // Expected {dp, dn, se0, d} is NRZI from J, LSB first, stuffed after six 1s
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        ones++;
      end else begin
        ones = 0;
        lvl  = ~lvl;
      end
      line_q.push_back({lvl, ~lvl, 1'b0, lvl});
      if (ones == 6) begin
        ones = 0;
        lvl  = ~lvl;
        line_q.push_back({lvl, ~lvl, 1'b0, lvl});
      end
    end
    // EOP is two SE0 bits then J
    line_q.push_back({3'b001, lvl});
    line_q.push_back({3'b001, lvl});
    line_q.push_back(4'b1001);

    @(posedge clk);
    tx_byte  <= b;
    tx_valid <= 1'b1;
    @(posedge clk);
    tx_valid <= 1'b0;
    waited = 0;
    @(negedge clk);
    while (!tx_busy && waited < BusyWait) begin
      @(negedge clk);
      waited++;
    end
    if (!tx_busy) begin
      $display("%s: tx_busy_o never rose after the byte strobe", name);
      errors++;
    end else begin
      // Busy is due the cycle after the strobe
      check_value(name, 16'd0, 16'(waited));
      repeat (2) @(negedge clk);
      for (int k = 0; k < line_q.size(); k++) begin
        if (k == 2) begin
          // Mid-byte event is an override write or a second strobe to be ignored
          @(posedge clk);
          if (ovr) begin
            reg_we    <= 1'b1;
            reg_addr  <= ADDR_DRIVE;
            reg_wdata <= w;
          end else begin
            tx_valid <= 1'b1;
            tx_byte  <= ~b;
          end
          @(posedge clk);
          reg_we   <= 1'b0;
          tx_valid <= 1'b0;
          ovr_on = ovr;
          repeat (3) @(negedge clk);
        end else if (k > 0) begin
          repeat (ClksPerBit) @(negedge clk);
        end
        exp = ovr_on ? {1'b1, w[3], w[7], w[6], w[4], w[5]} : {2'b11, line_q[k]};
        check_value(name, 16'(exp),
                    16'({tx_busy, usb_tx_oe, usb_tx_dp, usb_tx_dn, usb_tx_se0, usb_tx_d}));
      end
      // One bit after the final J the engine is idle again
      repeat (ClksPerBit) @(negedge clk);
      exp = ovr_on ? {1'b0, w[3], w[7], w[6], w[4], w[5]} : 6'b001001;
      check_value(name, 16'(exp),
                  16'({tx_busy, usb_tx_oe, usb_tx_dp, usb_tx_dn, usb_tx_se0, usb_tx_d}));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Table
  ////////////////////////////////////////////////////////////

  function automatic void build_table();
    logic [15:0] w;
    logic [15:0] c;
    logic [3:0]  s;
    add_entry("reset_pins", K_PIN_CHECK, ADDR_DRIVE, 16'h0, IdlePins);
    add_entry("reset_drive", K_READ, ADDR_DRIVE, 16'h0, 16'h0);
    add_entry("reset_sense", K_READ, ADDR_SENSE, 16'h0, {11'h000, IdleTxSense});
    add_entry("reset_ctrl", K_READ, ADDR_CTRL, 16'h0, 16'h0);
    // Override with en forced on and random upper bits
    for (int i = 0; i < 3; i++) begin
      w = rand_bits(16) | 16'h0100;
      add_entry($sformatf("override_wr_%0d", i), K_WRITE, ADDR_DRIVE, w, 16'h0);
      add_entry($sformatf("override_pins_%0d", i), K_PIN_CHECK, ADDR_DRIVE, 16'h0,
                drive_pins(w));
      add_entry($sformatf("override_rd_%0d", i), K_READ, ADDR_DRIVE, 16'h0, {7'h00, w[8:0]});
    end
    add_entry("override_clear", K_WRITE, ADDR_DRIVE, 16'h0, 16'h0);
    add_entry("override_idle", K_PIN_CHECK, ADDR_DRIVE, 16'h0, IdlePins);
    // Pin-set data is {rx_dp, rx_dn, rx_d, sense}
    s = '0;
    for (int i = 0; i < 3; i++) begin
      w = rand_bits(4);
      s = w[3:0];
      add_entry($sformatf("sense_set_%0d", i), K_PIN_SET, ADDR_DRIVE, w, 16'h0);
      add_entry($sformatf("sense_rd_%0d", i), K_READ, ADDR_SENSE, 16'h0,
                {7'h00, s, IdleTxSense});
    end
    for (int i = 0; i < 3; i++) begin
      c = rand_bits(16);
      w = rand_bits(16);
      add_entry($sformatf("ctrl_wr_%0d", i), K_WRITE, ADDR_CTRL, c, 16'h0);
      add_entry($sformatf("ctrl_pins_%0d", i), K_PIN_CHECK, ADDR_DRIVE, 16'h0,
                {IdlePins[15:3], c[0], c[1], c[2]});
      add_entry($sformatf("sense_wr_%0d", i), K_WRITE, ADDR_SENSE, w, 16'h0);
      add_entry($sformatf("sense_wr_pins_%0d", i), K_PIN_CHECK, ADDR_DRIVE, 16'h0,
                {IdlePins[15:3], c[0], c[1], c[2]});
      add_entry($sformatf("ctrl_rd_%0d", i), K_READ, ADDR_CTRL, 16'h0, {13'h0000, c[2:0]});
    end
    add_entry("sense_after_wr", K_READ, ADDR_SENSE, 16'h0, {7'h00, s, IdleTxSense});
    add_entry("ctrl_clear", K_WRITE, ADDR_CTRL, 16'h0, 16'h0);
    // Fixed corner bytes then random ones
    for (int i = 0; i < 8; i++) begin
      case (i)
        0:       w = 16'h00ff;
        1:       w = 16'h0000;
        2:       w = 16'h00fc;
        3:       w = 16'h003f;
        default: w = rand_bits(8);
      endcase
      add_entry($sformatf("send_%0d", i), K_SEND, ADDR_DRIVE, w, 16'h0);
      add_entry($sformatf("send_idle_%0d", i), K_PIN_CHECK, ADDR_DRIVE, 16'h0, IdlePins);
    end
    // Bit 8 of the data marks an override mid-byte and exp holds the drive value
    w = rand_bits(8);
    c = rand_bits(16) | 16'h0100;
    add_entry("send_override", K_SEND, ADDR_DRIVE, w | 16'h0100, c);
    add_entry("send_override_clear", K_WRITE, ADDR_DRIVE, 16'h0, 16'h0);
    add_entry("send_override_idle", K_PIN_CHECK, ADDR_DRIVE, 16'h0, IdlePins);
  endfunction

  task automatic apply_entry(input int i);
    logic [15:0] d;
    logic [15:0] rd;
    d = t_data[i];
    case (t_kind[i])
      K_WRITE: bus_write(t_addr[i], d);
      K_READ: begin
        bus_read(t_addr[i], rd);
        check_value(t_name[i], t_exp[i], rd);
      end
      K_PIN_SET: begin
        @(posedge clk);
        usb_rx_dp <= d[3];
        usb_rx_dn <= d[2];
        usb_rx_d  <= d[1];
        usb_sense <= d[0];
        // Two sync stages plus one spare edge
        repeat (3) @(posedge clk);
      end
      K_PIN_CHECK: begin
        @(negedge clk);
        check_value(t_name[i], t_exp[i], {8'h00, pins_now});
      end
      default: send_byte(t_name[i], d[7:0], d[8], t_exp[i]);
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int total;
    rst_n     = 1'b0;
    reg_we    = 1'b0;
    reg_re    = 1'b0;
    reg_addr  = ADDR_DRIVE;
    reg_wdata = '0;
    tx_byte   = '0;
    tx_valid  = 1'b0;
    usb_rx_d  = 1'b0;
    usb_rx_dp = 1'b0;
    usb_rx_dn = 1'b0;
    usb_sense = 1'b0;
    build_table();
    total = RstCycles;
    for (int i = 0; i < t_kind.size(); i++) begin
      total += entry_cycles(t_kind[i]);
    end
    cycle_limit = total * 12 / 10;

    repeat (RstCycles) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < t_kind.size(); i++) begin
      apply_entry(i);
    end

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
design/usb_phy_pkg.sv
design/usb_pin_if.sv
design/usb_phy_csr.sv
design/usb_tx_serializer.sv
design/usb_iomux.sv
design/usb_phy_top.sv
tests/usb_phy_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the USB PHY testbench with Verilator
verilator --binary --timing --assert --top-module usb_phy_tb -f project.f \
  && ./obj_dir/Vusb_phy_tb | tee /dev/stderr | grep -qx "Finished with no errors" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
